// File: rtl/nmi_pkg.sv
//////////////////////////////
// NMI controller package
// Bus limits, retire limits, signal bundles and FSM states
//////////////////////////////

`default_nettype none

package nmi_pkg;

  //////////////////////////////
  // Limits
  //////////////////////////////

  // Deepest the data bus may pipeline transactions
  localparam int MAX_OUTSTANDING = 2;
  // Shared width of the outstanding count and the retire count
  localparam int CNT_W = 2;
  // One instruction already retired together with the error
  localparam int RETIRE_LIMIT_AT_ERROR = 1;
  // No retirement in the error cycle, so two may still go
  localparam int RETIRE_LIMIT = 2;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // Data bus request channel as seen at the core boundary
  typedef struct packed {
    logic req;
    logic gnt;
    logic we;
  } obi_req_t;

  // Data bus response channel
  typedef struct packed {
    logic rvalid;
    logic err;
  } obi_resp_t;

  // Writeback stage status
  typedef struct packed {
    logic valid;
    logic last_op;
    logic fencei;
  } wb_status_t;

  // NMI outputs towards the trap logic
  typedef struct packed {
    logic pending;
    logic is_store;
    logic take;
  } nmi_status_t;

  // Flush handshake states
  typedef enum logic [1:0] {
    RUN,
    FLUSH_REQ,
    FLUSH_DONE
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/outstanding_tracker.sv
//////////////////////////////
// Outstanding tracker
// Counts bus transactions in flight and queues their types
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module outstanding_tracker
  import nmi_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  obi_req_t         obi_req_i,
  input  obi_resp_t        obi_resp_i,
  output logic [CNT_W-1:0] count_o,
  output logic             oldest_we_o
);

  logic                       accept;
  logic                       respond;
  logic [CNT_W-1:0]           count_q;
  // Newest type sits at index 0, older entries shift upwards
  logic [MAX_OUTSTANDING-1:0] type_q;

  // A transaction is accepted on req and gnt in the same cycle
  assign accept  = obi_req_i.req && obi_req_i.gnt;
  // Every rvalid completes the oldest transaction
  assign respond = obi_resp_i.rvalid;

  //////////////////////////////
  // Count
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      if (accept && !respond) begin
        count_q <= count_q + 1'b1;
      end else if (respond && !accept) begin
        count_q <= count_q - 1'b1;
      end
      // Accept and response together leave the count level
    end
  end

  //////////////////////////////
  // Type queue
  //////////////////////////////

  // Each accepted request shifts its we bit in at the bottom
  // A pop needs no data movement, the oldest entry is found from the count
  always_ff @(posedge clk) begin
    if (accept) begin
      type_q <= {type_q[MAX_OUTSTANDING-2:0], obi_req_i.we};
    end
  end

  // With a full queue the oldest is at the top, otherwise at the bottom
  assign oldest_we_o = (count_q == CNT_W'(MAX_OUTSTANDING)) ? type_q[MAX_OUTSTANDING-1]
                                                             : type_q[0];

  assign count_o = count_q;

endmodule

`default_nettype wire

// File: rtl/bus_error_latch.sv
//////////////////////////////
// Bus error latch
// Holds the first bus error as a pending NMI
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bus_error_latch
  import nmi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  obi_resp_t obi_resp_i,
  input  logic      oldest_we_i,
  input  logic      retire_i,
  input  logic      nmi_take_i,
  output logic      pending_o,
  output logic      is_store_o,
  output logic      retire_at_error_o
);

  logic new_error;
  logic pending_q;
  logic is_store_q;
  logic retire_at_error_q;

  // Only the first erroring response counts, later ones are dropped
  assign new_error = obi_resp_i.rvalid && obi_resp_i.err && !pending_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q         <= 1'b0;
      is_store_q        <= 1'b0;
      retire_at_error_q <= 1'b0;
    end else begin
      if (new_error) begin
        pending_q         <= 1'b1;
        // The failing access is the oldest one still outstanding
        is_store_q        <= oldest_we_i;
        // Remember if writeback retired in the same cycle as the error
        retire_at_error_q <= retire_i;
      end else if (nmi_take_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  assign pending_o         = pending_q;
  assign is_store_o        = is_store_q;
  assign retire_at_error_o = retire_at_error_q;

endmodule

`default_nettype wire

// File: rtl/retire_counter.sv
//////////////////////////////
// Retire counter
// Counts retirements while an NMI waits
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module retire_counter
  import nmi_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic pending_i,
  input  logic count_en_i,
  input  logic retire_at_error_i,
  input  logic nmi_take_i,
  output logic limit_reached_o
);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] limit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      // Start from zero for every new NMI
      if (!pending_i || nmi_take_i) begin
        cnt_q <= '0;
      end else if (count_en_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // A retirement in the error cycle already used up one slot
  assign limit = retire_at_error_i ? CNT_W'(RETIRE_LIMIT_AT_ERROR) : CNT_W'(RETIRE_LIMIT);

  // Once reached, the next instruction must not retire before the NMI
  assign limit_reached_o = (cnt_q >= limit);

endmodule

`default_nettype wire

// File: rtl/ctrl_fsm.sv
//////////////////////////////
// Controller FSM
// NMI entry decision and fence.i flush handshake
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm
  import nmi_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  wb_status_t       wb_i,
  input  logic             debug_mode_i,
  input  logic             pending_i,
  input  logic             limit_reached_i,
  input  logic [CNT_W-1:0] outstanding_cnt_i,
  input  logic             fencei_flush_ack_i,
  output logic             nmi_take_o,
  output logic             count_en_o,
  output logic             fencei_flush_req_o,
  output logic             fencei_done_o,
  output logic             wb_halt_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        retire_wb;
  logic        fencei_in_wb;
  logic        nmi_allowed;
  logic        flush_start;

  //////////////////////////////
  // NMI entry
  //////////////////////////////

  assign retire_wb    = wb_i.valid && wb_i.last_op;
  assign fencei_in_wb = wb_i.valid && wb_i.fencei;

  // Debug mode defers the NMI and freezes the retire count
  assign nmi_allowed = pending_i && !debug_mode_i;

  // Take at the retire limit, or at once when writeback is not retiring
  assign nmi_take_o = nmi_allowed && (limit_reached_i || !retire_wb);
  assign count_en_o = nmi_allowed && retire_wb;

  //////////////////////////////
  // Flush handshake
  //////////////////////////////

  // The bus must be drained and the NMI goes first
  // A take implies pending, so checking pending covers both
  assign flush_start = fencei_in_wb && (outstanding_cnt_i == '0) && !pending_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        if (flush_start) begin
          state_d = FLUSH_REQ;
        end
      end
      FLUSH_REQ: begin
        // Request stays up until the ack arrives
        if (fencei_flush_ack_i) begin
          state_d = FLUSH_DONE;
        end
      end
      FLUSH_DONE: begin
        state_d = RUN;
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign fencei_flush_req_o = (state_q == FLUSH_REQ);
  // Single cycle, the fence.i completes here
  assign fencei_done_o      = (state_q == FLUSH_DONE);
  // Writeback holds from fence.i arrival through the done cycle
  assign wb_halt_o = ((state_q == RUN) && fencei_in_wb) || (state_q != RUN);

endmodule

`default_nettype wire

// File: rtl/nmi_ctrl_top.sv
//////////////////////////////
// NMI controller top
// Bus error NMI and fence.i flush control
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nmi_ctrl_top
  import nmi_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  obi_req_t    obi_req_i,
  input  obi_resp_t   obi_resp_i,
  input  wb_status_t  wb_i,
  input  logic        debug_mode_i,
  input  logic        fencei_flush_ack_i,
  output nmi_status_t nmi_status_o,
  output logic        fencei_flush_req_o,
  output logic        fencei_done_o,
  output logic        wb_halt_o
);

  logic [CNT_W-1:0] outstanding_cnt;
  logic             oldest_we;
  logic             retire_wb;
  logic             pending;
  logic             is_store;
  logic             retire_at_error;
  logic             limit_reached;
  logic             count_en;
  logic             nmi_take;

  // Writeback retires on the last operation of an instruction
  assign retire_wb = wb_i.valid && wb_i.last_op;

  outstanding_tracker tracker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .obi_req_i   (obi_req_i),
    .obi_resp_i  (obi_resp_i),
    .count_o     (outstanding_cnt),
    .oldest_we_o (oldest_we)
  );

  bus_error_latch latch_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .obi_resp_i        (obi_resp_i),
    .oldest_we_i       (oldest_we),
    .retire_i          (retire_wb),
    .nmi_take_i        (nmi_take),
    .pending_o         (pending),
    .is_store_o        (is_store),
    .retire_at_error_o (retire_at_error)
  );

  retire_counter counter_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .pending_i         (pending),
    .count_en_i        (count_en),
    .retire_at_error_i (retire_at_error),
    .nmi_take_i        (nmi_take),
    .limit_reached_o   (limit_reached)
  );

  ctrl_fsm fsm_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .wb_i               (wb_i),
    .debug_mode_i       (debug_mode_i),
    .pending_i          (pending),
    .limit_reached_i    (limit_reached),
    .outstanding_cnt_i  (outstanding_cnt),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .nmi_take_o         (nmi_take),
    .count_en_o         (count_en),
    .fencei_flush_req_o (fencei_flush_req_o),
    .fencei_done_o      (fencei_done_o),
    .wb_halt_o          (wb_halt_o)
  );

  assign nmi_status_o = '{pending: pending, is_store: is_store, take: nmi_take};

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset is released on a rising edge like any other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
//////////////////////////////
// NMI controller testbench
// Directed and random stimulus compared with a cycle model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_top
  import nmi_pkg::*;
();

  localparam int RESET_CYCLES    = 8;
  localparam int DIRECTED_CYCLES = 100;
  localparam int RANDOM_CYCLES   = 400;
  localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES);

  localparam obi_req_t   RQ_NONE  = '{req: 1'b0, gnt: 1'b0, we: 1'b0};
  localparam obi_req_t   RQ_LOAD  = '{req: 1'b1, gnt: 1'b1, we: 1'b0};
  localparam obi_req_t   RQ_STORE = '{req: 1'b1, gnt: 1'b1, we: 1'b1};
  localparam obi_resp_t  RS_NONE  = '{rvalid: 1'b0, err: 1'b0};
  localparam obi_resp_t  RS_ERR   = '{rvalid: 1'b1, err: 1'b1};
  localparam wb_status_t WB_NONE  = '{valid: 1'b0, last_op: 1'b0, fencei: 1'b0};
  localparam wb_status_t WB_RET   = '{valid: 1'b1, last_op: 1'b1, fencei: 1'b0};
  localparam wb_status_t WB_FENCE = '{valid: 1'b1, last_op: 1'b0, fencei: 1'b1};

  // Model state, type queue has the oldest entry at index 0
  typedef struct packed {
    logic [CNT_W-1:0]           count;
    logic [MAX_OUTSTANDING-1:0] types;
    logic                       pending;
    logic                       is_store;
    logic                       rae;
    logic [CNT_W-1:0]           rcnt;
    ctrl_state_e                fstate;
  } model_t;

  typedef struct packed {
    logic pending;
    logic is_store;
    logic take;
    logic flush_req;
    logic done;
    logic halt;
  } exp_t;

  logic        clk;
  logic        rst_n;
  obi_req_t    obi_req;
  obi_resp_t   obi_resp;
  wb_status_t  wb;
  logic        debug_mode;
  logic        flush_ack;
  nmi_status_t nmi_status;
  logic        flush_req;
  logic        fencei_done;
  logic        wb_halt;
  model_t      model_q = '0;
  exp_t        exp_q = '0;
  string       test_name = "reset";
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          seed = 32'h2db0f3b4;

  tb_clkgen #(.HALF_PERIOD(2), .RESET_CYCLES(RESET_CYCLES)) clkgen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  nmi_ctrl_top dut_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .obi_req_i          (obi_req),
    .obi_resp_i         (obi_resp),
    .wb_i               (wb),
    .debug_mode_i       (debug_mode),
    .fencei_flush_ack_i (flush_ack),
    .nmi_status_o       (nmi_status),
    .fencei_flush_req_o (flush_req),
    .fencei_done_o      (fencei_done),
    .wb_halt_o          (wb_halt)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Outputs of the current cycle from the model state and the live inputs
  function automatic exp_t expected_outputs(input model_t m, input wb_status_t w,
                                            input logic dbg);
    exp_t e;
    int   limit;
    logic retire;
    limit = m.rae ? RETIRE_LIMIT_AT_ERROR : RETIRE_LIMIT;
    retire = w.valid && w.last_op;
    e.pending = m.pending;
    e.is_store = m.is_store;
    // Entry at the retire limit or as soon as writeback does not retire
    e.take = m.pending && !dbg && ((int'(m.rcnt) >= limit) || !retire);
    e.flush_req = (m.fstate == FLUSH_REQ);
    e.done = (m.fstate == FLUSH_DONE);
    e.halt = (m.fstate != RUN) || (w.valid && w.fencei);
    return e;
  endfunction

  // State after the coming rising edge
  function automatic model_t next_model(input model_t m, input obi_req_t rq,
                                        input obi_resp_t rs, input wb_status_t w,
                                        input logic dbg, input logic ack);
    model_t n;
    exp_t   e;
    logic   retire;
    n = m;
    e = expected_outputs(m, w, dbg);
    retire = w.valid && w.last_op;
    // A response completes the oldest transaction, an error records its type
    if (rs.rvalid) begin
      if (rs.err && !m.pending) begin
        n.pending = 1'b1;
        n.is_store = m.types[0];
        n.rae = retire;
      end
      n.types[0] = m.types[1];
      n.count = m.count - 1'b1;
    end
    if (e.take) begin
      n.pending = 1'b0;
    end
    if (rq.req && rq.gnt) begin
      if (n.count == '0) begin
        n.types[0] = rq.we;
      end else begin
        n.types[1] = rq.we;
      end
      n.count = n.count + 1'b1;
    end
    if (!m.pending || e.take) begin
      n.rcnt = '0;
    end else if (!dbg && retire) begin
      n.rcnt = m.rcnt + 1'b1;
    end
    case (m.fstate)
      RUN: begin
        if (w.valid && w.fencei && (m.count == '0) && !m.pending) begin
          n.fstate = FLUSH_REQ;
        end
      end
      FLUSH_REQ: begin
        if (ack) begin
          n.fstate = FLUSH_DONE;
        end
      end
      default: begin
        n.fstate = RUN;
      end
    endcase
    return n;
  endfunction

  task automatic check_bit(input string sig, input logic exp_v, input logic act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("Fail %s (%s): expected %0b, actual %0b", test_name, sig, exp_v, act_v);
    end
  endtask

  // Outputs are stable at the falling edge, the model steps there too
  always @(negedge clk) begin
    exp_t e;
    e = expected_outputs(model_q, wb, debug_mode);
    check_bit("pending", e.pending, nmi_status.pending);
    check_bit("is_store", e.is_store, nmi_status.is_store);
    check_bit("take", e.take, nmi_status.take);
    check_bit("flush_req", e.flush_req, flush_req);
    check_bit("done", e.done, fencei_done);
    check_bit("halt", e.halt, wb_halt);
    exp_q = e;
    if (!rst_n) begin
      model_q = '0;
    end else begin
      model_q = next_model(model_q, obi_req, obi_resp, wb, debug_mode, flush_ack);
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic drive(input obi_req_t rq, input obi_resp_t rs, input wb_status_t w,
                       input logic dbg, input logic ack);
    obi_req    <= rq;
    obi_resp   <= rs;
    wb         <= w;
    debug_mode <= dbg;
    flush_ack  <= ack;
  endtask

  task automatic step(input obi_req_t rq, input obi_resp_t rs, input wb_status_t w,
                      input logic dbg, input logic ack);
    @(posedge clk);
    drive(rq, rs, w, dbg, ack);
  endtask

  initial begin
    logic [31:0] r;
    obi_req_t    rq;
    obi_resp_t   rs;
    wb_status_t  w;
    int          i;
    obi_req = RQ_NONE;
    obi_resp = RS_NONE;
    wb = WB_NONE;
    debug_mode = 1'b0;
    flush_ack = 1'b0;
    @(posedge rst_n);
    repeat (2) step(RQ_NONE, RS_NONE, WB_NONE, 1'b0, 1'b0);

    // Load and store errors each raise an NMI taken at once
    test_name = "load_error";
    step(RQ_LOAD, RS_NONE, WB_NONE, 1'b0, 1'b0);
    step(RQ_NONE, RS_ERR, WB_NONE, 1'b0, 1'b0);
    repeat (3) step(RQ_NONE, RS_NONE, WB_NONE, 1'b0, 1'b0);
    test_name = "store_error";
    step(RQ_STORE, RS_NONE, WB_NONE, 1'b0, 1'b0);
    step(RQ_NONE, RS_ERR, WB_NONE, 1'b0, 1'b0);
    repeat (3) step(RQ_NONE, RS_NONE, WB_NONE, 1'b0, 1'b0);

    // Store fails first, the load error after it must not overwrite the type
    test_name = "second_error_debug";
    step(RQ_STORE, RS_NONE, WB_NONE, 1'b1, 1'b0);
    step(RQ_LOAD, RS_NONE, WB_NONE, 1'b1, 1'b0);
    step(RQ_NONE, RS_ERR, WB_NONE, 1'b1, 1'b0);
    step(RQ_NONE, RS_ERR, WB_RET, 1'b1, 1'b0);
    repeat (3) step(RQ_NONE, RS_NONE, WB_RET, 1'b1, 1'b0);
    // Leaving debug, two retirements may pass before the take
    repeat (4) step(RQ_NONE, RS_NONE, WB_RET, 1'b0, 1'b0);
    step(RQ_NONE, RS_NONE, WB_NONE, 1'b0, 1'b0);

    test_name = "retire_at_error";
    step(RQ_LOAD, RS_NONE, WB_NONE, 1'b0, 1'b0);
    step(RQ_NONE, RS_ERR, WB_RET, 1'b0, 1'b0);
    repeat (3) step(RQ_NONE, RS_NONE, WB_RET, 1'b0, 1'b0);
    step(RQ_NONE, RS_NONE, WB_NONE, 1'b0, 1'b0);

    // fence.i waits for the load to drain, then for the deferred NMI
    test_name = "flush";
    step(RQ_LOAD, RS_NONE, WB_NONE, 1'b1, 1'b0);
    repeat (2) step(RQ_NONE, RS_NONE, WB_FENCE, 1'b1, 1'b0);
    step(RQ_NONE, RS_ERR, WB_FENCE, 1'b1, 1'b0);
    repeat (3) step(RQ_NONE, RS_NONE, WB_FENCE, 1'b1, 1'b0);
    step(RQ_NONE, RS_NONE, WB_FENCE, 1'b0, 1'b0);
    @(negedge clk);
    while (!flush_req) @(negedge clk);
    r = $random(seed);
    repeat (r[2:0]) step(RQ_NONE, RS_NONE, WB_FENCE, 1'b0, 1'b0);
    step(RQ_NONE, RS_NONE, WB_FENCE, 1'b0, 1'b1);
    step(RQ_NONE, RS_NONE, WB_FENCE, 1'b0, 1'b0);
    @(negedge clk);
    while (!fencei_done) @(negedge clk);
    step(RQ_NONE, RS_NONE, WB_NONE, 1'b0, 1'b0);

    // Random traffic kept within two outstanding and held under wb_halt
    test_name = "random";
    for (i = 0; i < RANDOM_CYCLES; i++) begin
      @(posedge clk);
      r = $random(seed);
      rs.rvalid = (model_q.count != '0) && r[0];
      rs.err = (r[3:1] == 3'd0);
      rq.req = r[4];
      rq.gnt = r[5] && ((int'(model_q.count) < MAX_OUTSTANDING) || rs.rvalid);
      rq.we = r[6];
      if (exp_q.halt && !exp_q.done) begin
        w = wb;
      end else begin
        w.valid = r[7];
        w.fencei = (r[11:8] == 4'd0);
        w.last_op = r[12] && !w.fencei;
      end
      drive(rq, rs, w, r[15:13] == 3'd0, r[17:16] == 2'd0);
    end
    repeat (4) step(RQ_NONE, RS_NONE, WB_NONE, 1'b0, 1'b0);
    @(negedge clk);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Ends a run that never reaches the end of the stimulus
  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/nmi_pkg.sv
rtl/outstanding_tracker.sv
rtl/bus_error_latch.sv
rtl/retire_counter.sv
rtl/ctrl_fsm.sv
rtl/nmi_ctrl_top.sv
tb/tb_clkgen.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the NMI controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_top -Mdir "$build_dir" -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/tb_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$log_file"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1
